//--- gb_irq_config.svh
`ifndef GB_IRQ_CONFIG_SVH
`define GB_IRQ_CONFIG_SVH

// ------------------------------------------------------------
// Interrupt lines
// ------------------------------------------------------------

// vblank, lcd stat, timer, serial, joypad
`define IRQ_NUM 5

// ------------------------------------------------------------
// Register map and dispatch vectors
// ------------------------------------------------------------

`define IRQ_ADDR_IF 8'h0F
`define IRQ_ADDR_IE 8'hFF

// Line i jumps to base + i * stride
`define IRQ_VEC_BASE   8'h40
`define IRQ_VEC_STRIDE 8

`endif

//--- gb_irq_pkg.sv
`default_nettype none

package gb_irq_pkg;

	// ------------------------------------------------------------
	// Opcodes and sequencer states
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		NOP,
		EI,
		DI,
		RETI,
		HALT
	} cpu_op_e;

	typedef enum logic [1:0] {
		RUN,
		HALTED,
		ENTRY_ACK,    // Acknowledge cycle
		ENTRY_JUMP    // Report cycle
	} seq_state_e;

	// ------------------------------------------------------------
	// Bus and control bundles
	// ------------------------------------------------------------

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		logic [7:0] paddr;
		logic [7:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
		logic       pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic wr_en;    // One cycle write strobe
		logic wr_bit;
	} flag_ctl_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] vector;
	} entry_info_t;

endpackage

`default_nettype wire

//--- irq_flag_cell.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module irq_flag_cell (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  src,
	input  gb_irq_pkg::flag_ctl_t ctl,
	input  logic                  ack,
	output logic                  flag
);

	logic src_q;
	logic src_rise;

	// ------------------------------------------------------------
	// Edge detect on the raw request
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			src_q <= 1'b0;
		else
			src_q <= src;
	end

	assign src_rise = src && !src_q;    // Held level sets only once

	// ------------------------------------------------------------
	// Flag bit
	// ------------------------------------------------------------

	// A new request beats a bus write or an acknowledge in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			flag <= 1'b0;
		end else if (src_rise) begin
			flag <= 1'b1;
		end else if (ctl.wr_en) begin
			flag <= ctl.wr_bit;        // Bus write to IF
		end else if (ack) begin
			flag <= 1'b0;              // Taken by interrupt entry
		end
	end

endmodule

`default_nettype wire

//--- irq_reg_bus.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module irq_reg_bus (
	input  logic                                 clk,
	input  logic                                 reset,
	input  gb_irq_pkg::apb_req_t                 req,
	output gb_irq_pkg::apb_rsp_t                 rsp,
	input  logic [`IRQ_NUM-1:0]                  if_flags,
	output gb_irq_pkg::flag_ctl_t [`IRQ_NUM-1:0] flag_ctl,
	output logic [7:0]                           iena
);

	logic       access;
	logic       hit_if;
	logic       hit_ie;
	logic       if_we;
	logic       ie_we;
	logic [7:0] if_rd;
	logic [7:0] rd_data;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------

	assign access = req.psel && req.penable;    // APB access phase
	assign hit_if = (req.paddr == `IRQ_ADDR_IF);
	assign hit_ie = (req.paddr == `IRQ_ADDR_IE);

	assign if_we = access && req.pwrite && hit_if;
	assign ie_we = access && req.pwrite && hit_ie;

	// ------------------------------------------------------------
	// IE register
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			iena <= 8'h00;
		else if (ie_we)
			iena <= req.pwdata;    // All 8 bits stored
	end

	// ------------------------------------------------------------
	// IF write fan-out
	// ------------------------------------------------------------

	// Cells load on the edge that ends the access phase
	always_comb begin
		for (int i = 0; i < `IRQ_NUM; i++) begin
			flag_ctl[i].wr_en  = if_we;
			flag_ctl[i].wr_bit = req.pwdata[i];
		end
	end

	// ------------------------------------------------------------
	// Read data and response
	// ------------------------------------------------------------

	// Unused IF bits read back as 1
	assign if_rd = {{(8 - `IRQ_NUM){1'b1}}, if_flags};

	always_comb begin
		if (hit_if)
			rd_data = if_rd;
		else if (hit_ie)
			rd_data = iena;
		else
			rd_data = 8'h00;    // Unmapped offset
	end

	assign rsp.prdata  = rd_data;
	assign rsp.pready  = 1'b1;                          // No wait states
	assign rsp.pslverr = access && !(hit_if || hit_ie);

endmodule

`default_nettype wire

//--- sm83_int.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module sm83_int (
	input  logic                clk,
	input  logic                reset,
	input  logic [`IRQ_NUM-1:0] if_flags,
	input  logic [7:0]          iena,
	output logic                t1,
	output logic                t4,
	output logic                intr_entry,
	output logic [7:0]          int_vector,
	output logic [`IRQ_NUM-1:0] iack,
	output logic                wake,
	output logic                ime,
	input  logic                ctl_update_int,
	input  logic                ctl_ime_we,
	input  logic                ctl_ime_bit,
	input  logic                ctl_ack_int
);

	logic [1:0]          phase;
	logic                t2;
	logic [`IRQ_NUM-1:0] irq_latched;
	logic [`IRQ_NUM-1:0] wake_latched;
	logic [`IRQ_NUM-1:0] entry_req;

	// ------------------------------------------------------------
	// Machine cycle phases
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			phase <= 2'd0;    // Start at t1
		else
			phase <= phase + 2'd1;
	end

	assign t1 = (phase == 2'd0);
	assign t2 = (phase == 2'd1);
	assign t4 = (phase == 2'd3);

	// ------------------------------------------------------------
	// Master enable and entry decision
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			ime <= 1'b0;
		else if (ctl_ime_we)
			ime <= ctl_ime_bit;
	end

	always_ff @(posedge clk) begin
		if (reset)
			intr_entry <= 1'b0;
		else if (ctl_update_int)
			intr_entry <= ime && |entry_req;
	end

	// ------------------------------------------------------------
	// Flag sampling
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			irq_latched  <= '0;
			wake_latched <= '0;
		end else begin
			if (t2)
				irq_latched <= if_flags;     // For entry
			if (t4)
				wake_latched <= if_flags;    // For HALT exit
		end
	end

	assign entry_req = irq_latched & iena[`IRQ_NUM-1:0];

	// Wake ignores IME
	assign wake = t1 && |(wake_latched & iena[`IRQ_NUM-1:0]);

	// ------------------------------------------------------------
	// Priority vector and acknowledge
	// ------------------------------------------------------------

	// Lowest index wins, so scan from the top down
	always_comb begin
		int_vector = 8'h00;    // Nothing pending gives zero
		iack       = '0;
		for (int i = `IRQ_NUM - 1; i >= 0; i--) begin
			if (entry_req[i]) begin
				int_vector = `IRQ_VEC_BASE + 8'(i * `IRQ_VEC_STRIDE);
				iack       = '0;
				iack[i]    = ctl_ack_int;
			end
		end
	end

endmodule

`default_nettype wire

//--- int_entry_seq.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module int_entry_seq (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_irq_pkg::cpu_op_e     op,
	input  logic                    op_valid,
	input  logic                    t1,
	input  logic                    t4,
	input  logic                    intr_entry,
	input  logic [7:0]              int_vector,
	input  logic                    wake,
	output logic                    ctl_update_int,
	output logic                    ctl_ime_we,
	output logic                    ctl_ime_bit,
	output logic                    ctl_ack_int,
	output gb_irq_pkg::entry_info_t entry,
	output logic                    halted
);

	gb_irq_pkg::seq_state_e state;
	gb_irq_pkg::seq_state_e state_next;
	logic                   op_take;
	logic [7:0]             vec_q;

	assign op_take = (state == gb_irq_pkg::RUN) && t4 && op_valid;

	// ------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			gb_irq_pkg::RUN: begin
				// intr_entry is fresh on t1 after the t4 update
				if (t1 && intr_entry)
					state_next = gb_irq_pkg::ENTRY_ACK;
				else if (op_take && op == gb_irq_pkg::HALT)
					state_next = gb_irq_pkg::HALTED;
			end
			gb_irq_pkg::HALTED: begin
				if (wake)
					state_next = gb_irq_pkg::RUN;
			end
			gb_irq_pkg::ENTRY_ACK:  state_next = gb_irq_pkg::ENTRY_JUMP;
			gb_irq_pkg::ENTRY_JUMP: state_next = gb_irq_pkg::RUN;
			default:                state_next = gb_irq_pkg::RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= gb_irq_pkg::RUN;
		else
			state <= state_next;
	end

	// ------------------------------------------------------------
	// Controls into the interrupt unit
	// ------------------------------------------------------------

	always_comb begin
		ctl_update_int = 1'b0;
		ctl_ime_we     = 1'b0;
		ctl_ime_bit    = 1'b0;
		ctl_ack_int    = 1'b0;
		case (state)
			gb_irq_pkg::RUN: begin
				ctl_update_int = t4;
				if (op_take) begin
					case (op)
						gb_irq_pkg::EI, gb_irq_pkg::RETI: begin
							ctl_ime_we  = 1'b1;
							ctl_ime_bit = 1'b1;
						end
						gb_irq_pkg::DI: ctl_ime_we = 1'b1;
						default: ;    // NOP and HALT leave IME alone
					endcase
				end
			end
			gb_irq_pkg::ENTRY_ACK: begin
				ctl_ack_int = 1'b1;
				ctl_ime_we  = 1'b1;    // IME cleared on entry
			end
			default: ;
		endcase
	end

	// Vector held for the report cycle
	always_ff @(posedge clk) begin
		if (state == gb_irq_pkg::ENTRY_ACK)
			vec_q <= int_vector;
	end

	assign entry.valid  = (state == gb_irq_pkg::ENTRY_JUMP);
	assign entry.vector = vec_q;
	assign halted       = (state == gb_irq_pkg::HALTED);

endmodule

`default_nettype wire

//--- gb_irq_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module gb_irq_top (
	input  logic                    clk,
	input  logic                    reset,
	input  gb_irq_pkg::apb_req_t    apb_req,
	output gb_irq_pkg::apb_rsp_t    apb_rsp,
	input  logic [`IRQ_NUM-1:0]     irq_src,
	input  gb_irq_pkg::cpu_op_e     op,
	input  logic                    op_valid,
	output gb_irq_pkg::entry_info_t entry,
	output logic                    halted,
	output logic                    ime
);

	gb_irq_pkg::flag_ctl_t [`IRQ_NUM-1:0] flag_ctl;
	logic [`IRQ_NUM-1:0]                  if_flags;
	logic [`IRQ_NUM-1:0]                  iack;
	logic [7:0]                           iena;
	logic [7:0]                           int_vector;
	logic                                 t1;
	logic                                 t4;
	logic                                 intr_entry;
	logic                                 wake;
	logic                                 ctl_update_int;
	logic                                 ctl_ime_we;
	logic                                 ctl_ime_bit;
	logic                                 ctl_ack_int;

	// ------------------------------------------------------------
	// Register bus and flag cells
	// ------------------------------------------------------------

	irq_reg_bus u_bus (
		.clk      (clk),
		.reset    (reset),
		.req      (apb_req),
		.rsp      (apb_rsp),
		.if_flags (if_flags),
		.flag_ctl (flag_ctl),
		.iena     (iena)
	);

	for (genvar i = 0; i < `IRQ_NUM; i++) begin : g_flag
		irq_flag_cell u_cell (
			.clk   (clk),
			.reset (reset),
			.src   (irq_src[i]),
			.ctl   (flag_ctl[i]),
			.ack   (iack[i]),
			.flag  (if_flags[i])
		);
	end

	// ------------------------------------------------------------
	// Interrupt unit and entry sequencer
	// ------------------------------------------------------------

	sm83_int u_int (
		.clk            (clk),
		.reset          (reset),
		.if_flags       (if_flags),
		.iena           (iena),
		.t1             (t1),
		.t4             (t4),
		.intr_entry     (intr_entry),
		.int_vector     (int_vector),
		.iack           (iack),
		.wake           (wake),
		.ime            (ime),
		.ctl_update_int (ctl_update_int),
		.ctl_ime_we     (ctl_ime_we),
		.ctl_ime_bit    (ctl_ime_bit),
		.ctl_ack_int    (ctl_ack_int)
	);

	int_entry_seq u_seq (
		.clk            (clk),
		.reset          (reset),
		.op             (op),
		.op_valid       (op_valid),
		.t1             (t1),
		.t4             (t4),
		.intr_entry     (intr_entry),
		.int_vector     (int_vector),
		.wake           (wake),
		.ctl_update_int (ctl_update_int),
		.ctl_ime_we     (ctl_ime_we),
		.ctl_ime_bit    (ctl_ime_bit),
		.ctl_ack_int    (ctl_ack_int),
		.entry          (entry),
		.halted         (halted)
	);

endmodule

`default_nettype wire

//--- tb_gb_irq.sv
`timescale 1ns/1ns
`default_nettype none
`include "gb_irq_config.svh"

module tb_gb_irq;

	localparam int CLK_PERIOD  = 20;
	localparam int N_DIRECTED  = 9;
	localparam int N_RAND      = 4;
	localparam int N_ROWS      = N_DIRECTED + N_RAND;
	localparam int ENTRY_WAIT  = 40;    // Clocks allowed for one entry or wake
	localparam int WATCHDOG_NS = (N_ROWS + 1) * 40 * CLK_PERIOD;

	typedef struct packed {
		logic [7:0]          ie;
		logic                if_en;       // Write IF before the op
		logic [`IRQ_NUM-1:0] if_wr;
		logic [`IRQ_NUM-1:0] src;
		logic                hold;        // Keep src high and clear IF by write
		gb_irq_pkg::cpu_op_e op;
		logic [7:0]          exp_vec;     // Zero means no entry expected
		logic [7:0]          exp_if;
		logic                exp_halted;
	} row_t;

	logic                    clk = 1'b0;
	logic                    reset;
	gb_irq_pkg::apb_req_t    apb_req;
	gb_irq_pkg::apb_rsp_t    apb_rsp;
	logic [`IRQ_NUM-1:0]     irq_src;
	gb_irq_pkg::cpu_op_e     op;
	logic                    op_valid;
	gb_irq_pkg::entry_info_t entry;
	logic                    halted;
	logic                    ime;

	row_t       rows [N_ROWS];
	string      row_names [N_ROWS];
	string      cur_name;
	integer     seed;
	int         row_errs;
	int         test_count = 0;
	int         pass_count = 0;
	int         fail_count = 0;
	int         entry_count = 0;
	logic [7:0] last_vec = 8'h00;

	gb_irq_top UUT (
		.clk      (clk),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.irq_src  (irq_src),
		.op       (op),
		.op_valid (op_valid),
		.entry    (entry),
		.halted   (halted),
		.ime      (ime)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Count dispatches and keep the last reported vector
	always @(negedge clk) begin
		if (entry.valid) begin
			entry_count <= entry_count + 1;
			last_vec    <= entry.vector;
		end
	end

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	function automatic int lowest_pending(input logic [`IRQ_NUM-1:0] pend);
		int idx;
		idx = -1;
		for (int i = 0; i < `IRQ_NUM; i++) begin
			if (idx < 0 && pend[i])
				idx = i;
		end
		return idx;
	endfunction

	function automatic logic [7:0] model_vector(input logic [`IRQ_NUM-1:0] flags,
			input logic [7:0] ie);
		int idx;
		idx = lowest_pending(flags & ie[`IRQ_NUM-1:0]);
		if (idx < 0)
			return 8'h00;
		return 8'(`IRQ_VEC_BASE + idx * `IRQ_VEC_STRIDE);
	endfunction

	// IF readback once the winning flag has been taken
	function automatic logic [7:0] model_if_after(input logic [`IRQ_NUM-1:0] flags,
			input logic [7:0] ie);
		int                  idx;
		logic [`IRQ_NUM-1:0] left;
		idx  = lowest_pending(flags & ie[`IRQ_NUM-1:0]);
		left = flags;
		if (idx >= 0)
			left[idx] = 1'b0;
		return 8'hE0 | 8'(left);    // Bits 7..5 read as 1
	endfunction

	// ------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------

	task automatic set_row(input int idx, input string name, input logic [7:0] ie,
			input logic if_en, input logic [`IRQ_NUM-1:0] if_wr,
			input logic [`IRQ_NUM-1:0] src, input logic hold,
			input gb_irq_pkg::cpu_op_e op_code, input logic [7:0] exp_vec,
			input logic [7:0] exp_if, input logic exp_halted);
		row_names[idx]       = name;
		rows[idx].ie         = ie;
		rows[idx].if_en      = if_en;
		rows[idx].if_wr      = if_wr;
		rows[idx].src        = src;
		rows[idx].hold       = hold;
		rows[idx].op         = op_code;
		rows[idx].exp_vec    = exp_vec;
		rows[idx].exp_if     = exp_if;
		rows[idx].exp_halted = exp_halted;
	endtask

	task automatic build_table();
		logic [31:0]         rnd;
		logic [`IRQ_NUM-1:0] src_r;
		logic [7:0]          ie_r;
		set_row(0, "ie_if_readback", 8'hA0, 1'b1, 5'h15, 5'h00, 1'b0,
			gb_irq_pkg::NOP, 8'h00, 8'hF5, 1'b0);
		set_row(1, "edge_capture", 8'h00, 1'b1, 5'h00, 5'h0A, 1'b0,
			gb_irq_pkg::NOP, 8'h00, 8'hEA, 1'b0);
		set_row(2, "level_held", 8'h00, 1'b1, 5'h00, 5'h04, 1'b1,
			gb_irq_pkg::NOP, 8'h00, 8'hE0, 1'b0);
		set_row(3, "mask_ie_zero", 8'h00, 1'b1, 5'h1F, 5'h00, 1'b0,
			gb_irq_pkg::EI, 8'h00, 8'hFF, 1'b0);
		set_row(4, "mask_after_di", 8'h1F, 1'b1, 5'h1F, 5'h00, 1'b0,
			gb_irq_pkg::DI, 8'h00, 8'hFF, 1'b0);
		set_row(5, "priority_multi", 8'h1F, 1'b1, 5'h1A, 5'h00, 1'b0, gb_irq_pkg::EI,
			model_vector(5'h1A, 8'h1F), model_if_after(5'h1A, 8'h1F), 1'b0);
		set_row(6, "reti_next", 8'h1F, 1'b0, 5'h00, 5'h00, 1'b0, gb_irq_pkg::RETI,
			model_vector(5'h18, 8'h1F), model_if_after(5'h18, 8'h1F), 1'b0);
		set_row(7, "reti_last", 8'h1F, 1'b0, 5'h00, 5'h00, 1'b0, gb_irq_pkg::RETI,
			model_vector(5'h10, 8'h1F), model_if_after(5'h10, 8'h1F), 1'b0);
		for (int k = 0; k < N_RAND; k++) begin
			rnd   = $random(seed);
			src_r = rnd[`IRQ_NUM-1:0];
			if (src_r == '0)
				src_r = 5'h01;
			ie_r  = rnd[15:8] | 8'(src_r);    // Every source line enabled
			set_row(8 + k, $sformatf("random_%0d", k), ie_r, 1'b1, 5'h00, src_r, 1'b0,
				gb_irq_pkg::EI, model_vector(src_r, ie_r), model_if_after(src_r, ie_r), 1'b0);
		end
		set_row(N_ROWS - 1, "halt_wake", 8'h10, 1'b1, 5'h00, 5'h10, 1'b0,
			gb_irq_pkg::HALT, 8'h00, 8'hF0, 1'b0);
	endtask

	// ------------------------------------------------------------
	// Bus and op drivers
	// ------------------------------------------------------------

	task automatic check_value(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
			row_errs++;
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		@(negedge clk);
		apb_req.psel    = 1'b1;    // Setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;    // Access phase
		#(CLK_PERIOD / 4);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		assert (apb_rsp.pready === 1'b1) else begin
			$display("APB access to offset %h did not complete in its access phase", addr);
			row_errs++;
		end
		@(negedge clk);
		apb_req = '0;
	endtask

	// Four clocks always hold exactly one t4
	task automatic apply_op(input gb_irq_pkg::cpu_op_e op_code);
		@(negedge clk);
		op       = op_code;
		op_valid = 1'b1;
		repeat (4) @(negedge clk);
		op       = gb_irq_pkg::NOP;
		op_valid = 1'b0;
	endtask

	task automatic finish_test();
		test_count++;
		if (row_errs == 0) begin
			pass_count++;
			$display("test %s: ok", cur_name);
		end else begin
			fail_count++;
			$display("test %s: FAIL with %0d errors", cur_name, row_errs);
		end
	endtask

	// ------------------------------------------------------------
	// One table row
	// ------------------------------------------------------------

	task automatic run_row(input int n);
		row_t       r;
		int         count0;
		int         waited;
		logic [7:0] rdata;
		logic       err;
		r        = rows[n];
		cur_name = row_names[n];
		row_errs = 0;
		count0   = entry_count;
		if (r.if_en)
			apb_transfer(1'b1, `IRQ_ADDR_IF, 8'(r.if_wr), rdata, err);
		apply_op(r.op);
		if (r.op == gb_irq_pkg::HALT) begin
			assert (halted === 1'b1) else begin
				$display("%s: HALT did not raise halted", cur_name);
				row_errs++;
			end
		end
		apb_transfer(1'b1, `IRQ_ADDR_IE, r.ie, rdata, err);
		if (r.src != '0) begin
			@(negedge clk);
			irq_src = r.src;
			repeat (2) @(negedge clk);
			if (r.hold)
				apb_transfer(1'b1, `IRQ_ADDR_IF, 8'h00, rdata, err);
			else
				irq_src = '0;
		end
		if (r.op == gb_irq_pkg::HALT && !r.exp_halted) begin
			waited = 0;
			while (halted && waited < ENTRY_WAIT) begin
				@(negedge clk);
				waited++;
			end
			assert (halted === 1'b0) else begin
				$display("%s: halted stayed high with a pending enabled flag", cur_name);
				row_errs++;
			end
		end
		if (r.exp_vec != 8'h00) begin
			waited = 0;
			while (entry_count == count0 && waited < ENTRY_WAIT) begin
				@(negedge clk);
				waited++;
			end
			assert (entry_count != count0) else begin
				$display("%s: no interrupt entry within %0d clocks", cur_name, ENTRY_WAIT);
				row_errs++;
			end
			check_value("vector", r.exp_vec, last_vec);
			check_value("ime", 8'h00, 8'(ime));
		end else begin
			repeat (16) @(negedge clk);    // Masking window
		end
		apb_transfer(1'b0, `IRQ_ADDR_IE, 8'h00, rdata, err);
		check_value("IE readback", r.ie, rdata);
		apb_transfer(1'b0, `IRQ_ADDR_IF, 8'h00, rdata, err);
		check_value("IF readback", r.exp_if, rdata);
		check_value("pslverr", 8'h00, 8'(err));
		check_value("halted", 8'(r.exp_halted), 8'(halted));
		check_value("entry count", (r.exp_vec != 8'h00) ? 8'h01 : 8'h00,
			8'(entry_count - count0));
		@(negedge clk);
		irq_src = '0;
		finish_test();
	endtask

	task automatic check_unmapped();
		logic [7:0] rdata;
		logic [7:0] ie_before;
		logic       err;
		cur_name = "unmapped_offset";
		row_errs = 0;
		apb_transfer(1'b0, `IRQ_ADDR_IE, 8'h00, ie_before, err);
		apb_transfer(1'b1, 8'h10, 8'h5A, rdata, err);
		check_value("write pslverr", 8'h01, 8'(err));
		apb_transfer(1'b0, 8'h10, 8'h00, rdata, err);
		check_value("read pslverr", 8'h01, 8'(err));
		check_value("read data", 8'h00, rdata);
		apb_transfer(1'b0, `IRQ_ADDR_IE, 8'h00, rdata, err);
		check_value("IE after unmapped write", ie_before, rdata);
		finish_test();
	endtask

	// ------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------

	initial begin
		reset    = 1'b1;
		apb_req  = '0;
		irq_src  = '0;
		op       = gb_irq_pkg::NOP;
		op_valid = 1'b0;
		seed     = 32'h364b_ab2d;
		build_table();
		repeat (3) @(negedge clk);
		reset = 1'b0;
		for (int n = 0; n < N_ROWS; n++)
			run_row(n);
		check_unmapped();
		$display("Tests run %0d, passed %0d, failed %0d", test_count, pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
gb_irq_pkg.sv
irq_flag_cell.sv
irq_reg_bus.sv
sm83_int.sv
int_entry_seq.sv
gb_irq_top.sv
tb_gb_irq.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interrupt subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_gb_irq \
	--Mdir "$BUILD" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "Test failures found" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
